/* decodeCore.f */
hdl/mipsPkg.sv
hdl/mainDecoder.sv
hdl/branchUnit.sv
hdl/operandForward.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/decodeExecReg.sv
hdl/decodeCore.sv
verif/decodeCoreTb.sv

/* verif/decodeCoreTb.sv */
`default_nettype none

module decodeCoreTb import mipsPkg::*; ();

	localparam int NumCredits    = 2;
	localparam int Period        = 40;
	localparam int TimeoutCycles = 20;

	// one table row per instruction
	typedef struct packed {
		word_t    instr;
		word_t    pcPlus4;
		forward_t fwdA;
		forward_t fwdB;
		word_t    hiVal;
		word_t    loVal;
		word_t    cp0Val;
	} stimEntry_t;

	logic     clk;
	logic     arstN;
	word_t    instr;
	word_t    pcPlus4;
	logic     fetchExc;
	logic     instrValid;
	logic     instrReady;
	forward_t forwardA;
	forward_t forwardB;
	word_t    aluOutM;
	word_t    resultW;
	logic     stall;
	word_t    hi;
	word_t    lo;
	word_t    cp0Rd;
	regAddr_t cp0Ra;
	logic     wbEnable;
	regAddr_t wbAddr;
	word_t    wbData;
	logic     redirect;
	word_t    redirectTarget;
	logic     isJr;
	logic     creditReturn;
	logic     exValid;
	decOp_t   exOp;
	regAddr_t exRs;
	regAddr_t exRt;
	regAddr_t exRd;
	regAddr_t exShamt;
	word_t    exImm;
	word_t    exSrcA;
	word_t    exSrcB;
	word_t    exPcPlus4;
	logic     exFetchExc;
	logic     exReservedExc;

	stimEntry_t stimTable [$];
	word_t      shadowRegs [32];
	int         seed;
	int         checkCount;
	int         valueErrors;
	int         otherErrors;
	int         modelCredits;
	logic       prevAccept;
	int         acceptCount;
	bit         timedOut;

	decodeCore #(
		.NumCredits (NumCredits)
	) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #(Period / 2) clk = ~clk;
	end

	task automatic finishRun();
		$display("checks %0d, value errors %0d, other errors %0d",
			checkCount, valueErrors, otherErrors);
		if ((valueErrors + otherErrors) == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	endtask

	task automatic checkWord(input string name, input word_t expected, input word_t actual);
		checkCount++;
		if (actual !== expected) begin
			valueErrors++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkOp(input string name, input decOp_t expected, input decOp_t actual);
		checkCount++;
		if (actual !== expected) begin
			valueErrors++;
			$display("FAIL %s expected %s (%0d) actual %s (%0d)", name,
				expected.name(), expected, actual.name(), actual);
		end
	endtask

	task automatic checkAddr(input string name, input regAddr_t expected,
		input regAddr_t actual);
		checkCount++;
		if (actual !== expected) begin
			valueErrors++;
			$display("FAIL %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			valueErrors++;
			$display("FAIL %s expected %b actual %b", name, expected, actual);
		end
	endtask

	task automatic waitReady(input string what);
		int cycles;
		cycles = 0;
		while (!instrReady && (cycles < TimeoutCycles)) begin
			@(negedge clk);
			#(Period / 4);
			cycles++;
		end
		if (!instrReady) begin
			otherErrors++;
			timedOut = 1'b1;
			$display("instrReady did not rise within %0d cycles during %s",
				TimeoutCycles, what);
		end
	endtask

	function automatic word_t rType(regAddr_t rs, regAddr_t rt, regAddr_t rd,
		logic [4:0] shamt, logic [5:0] funct);
		return {6'b000000, rs, rt, rd, shamt, funct};
	endfunction

	function automatic word_t iType(logic [5:0] opc, regAddr_t rs, regAddr_t rt,
		logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic word_t jType(logic [5:0] opc, logic [25:0] index);
		return {opc, index};
	endfunction

	// reference decode from the MIPS opcode map
	function automatic decOp_t decodeWord(word_t word);
		logic [5:0] opc;
		logic [5:0] fn;
		opc = word[31:26];
		fn  = word[5:0];
		case (opc)
			6'h00: begin
				case (fn)
					6'h21:   return ADDU;
					6'h23:   return SUBU;
					6'h24:   return AND;
					6'h25:   return OR;
					6'h2a:   return SLT;
					6'h10:   return MFHI;
					6'h12:   return MFLO;
					6'h08:   return JR;
					default: return RESERVED;
				endcase
			end
			6'h02:   return J;
			6'h03:   return JAL;
			6'h04:   return BEQ;
			6'h05:   return BNE;
			6'h06:   return BLEZ;
			6'h07:   return BGTZ;
			6'h09:   return ADDIU;
			6'h0c:   return ANDI;
			6'h0d:   return ORI;
			6'h0f:   return LUI;
			6'h23:   return LW;
			6'h2b:   return SW;
			6'h10:   return (word[25:21] == 5'd0) ? MFC0 : RESERVED;
			default: return RESERVED;
		endcase
	endfunction

	function automatic word_t extendImm(word_t word, decOp_t op);
		case (op)
			ANDI, ORI: return {16'h0000, word[15:0]};
			LUI:       return {word[15:0], 16'h0000};
			default:   return {{16{word[15]}}, word[15:0]};
		endcase
	endfunction

	function automatic word_t fwdValue(forward_t sel, regAddr_t idx);
		case (sel)
			FWD_MEM: return aluOutM;
			FWD_WB:  return resultW;
			default: return (idx == 5'd0) ? 32'h0 : shadowRegs[idx];
		endcase
	endfunction

	task automatic addStim(input word_t word, input word_t pc, input forward_t fA,
		input forward_t fB, input word_t hiVal, input word_t loVal, input word_t cp0Val);
		stimEntry_t entry;
		entry.instr   = word;
		entry.pcPlus4 = pc;
		entry.fwdA    = fA;
		entry.fwdB    = fB;
		entry.hiVal   = hiVal;
		entry.loVal   = loVal;
		entry.cp0Val  = cp0Val;
		stimTable.push_back(entry);
	endtask

	task automatic writeReg(input regAddr_t idx, input word_t value);
		@(negedge clk);
		wbEnable = 1'b1;
		wbAddr   = idx;
		wbData   = value;
		if (idx != 5'd0) begin
			shadowRegs[idx] = value;
		end
	endtask

	task automatic applyEntry(input int idx, input stimEntry_t entry);
		string    name;
		decOp_t   expOp;
		word_t    valA;
		word_t    valB;
		word_t    expSrcA;
		word_t    expTarget;
		logic     expTaken;
		logic     expRedirect;
		regAddr_t rsF;
		regAddr_t rtF;
		name  = $sformatf("entry %0d", idx);
		rsF   = entry.instr[25:21];
		rtF   = entry.instr[20:16];
		expOp = decodeWord(entry.instr);
		@(negedge clk);
		instr        = entry.instr;
		pcPlus4      = entry.pcPlus4;
		forwardA     = entry.fwdA;
		forwardB     = entry.fwdB;
		hi           = entry.hiVal;
		lo           = entry.loVal;
		cp0Rd        = entry.cp0Val;
		aluOutM      = $random(seed);
		resultW      = $random(seed);
		fetchExc     = ((idx % 3) == 1);
		instrValid   = 1'b1;
		creditReturn = 1'b0;
		#(Period / 4);
		waitReady(name);
		if (timedOut) begin
			return;
		end
		valA = fwdValue(entry.fwdA, rsF);
		valB = fwdValue(entry.fwdB, rtF);
		case (expOp)
			MFHI:    expSrcA = entry.hiVal;
			MFLO:    expSrcA = entry.loVal;
			MFC0:    expSrcA = entry.cp0Val;
			default: expSrcA = valA;
		endcase
		case (expOp)
			BEQ:     expTaken = (valA == valB);
			BNE:     expTaken = (valA != valB);
			BLEZ:    expTaken = ($signed(valA) <= 0);
			BGTZ:    expTaken = ($signed(valA) > 0);
			default: expTaken = 1'b0;
		endcase
		expRedirect = expTaken || (expOp inside {J, JAL, JR});
		if (expOp == JR) begin
			expTarget = valA;
		end else if (expOp inside {J, JAL}) begin
			expTarget = {entry.pcPlus4[31:28], entry.instr[25:0], 2'b00};
		end else begin
			expTarget = entry.pcPlus4 + (extendImm(entry.instr, BEQ) << 2);
		end
		// redirect side is sampled in the accepting cycle
		checkBit($sformatf("%s redirect", name), expRedirect, redirect);
		if (expRedirect) begin
			checkWord($sformatf("%s redirectTarget", name), expTarget, redirectTarget);
		end
		checkBit($sformatf("%s isJr", name), expOp == JR, isJr);
		checkAddr($sformatf("%s cp0Ra", name), entry.instr[15:11], cp0Ra);
		@(negedge clk);
		instrValid   = 1'b0;
		creditReturn = 1'b1;
		#(Period / 4);
		checkBit($sformatf("%s exValid", name), 1'b1, exValid);
		checkOp($sformatf("%s exOp", name), expOp, exOp);
		checkAddr($sformatf("%s exRs", name), rsF, exRs);
		checkAddr($sformatf("%s exRt", name), rtF, exRt);
		checkAddr($sformatf("%s exRd", name), entry.instr[15:11], exRd);
		checkAddr($sformatf("%s exShamt", name), entry.instr[10:6], exShamt);
		checkWord($sformatf("%s exImm", name), extendImm(entry.instr, expOp), exImm);
		checkWord($sformatf("%s exSrcA", name), expSrcA, exSrcA);
		checkWord($sformatf("%s exSrcB", name), valB, exSrcB);
		checkWord($sformatf("%s exPcPlus4", name), entry.pcPlus4, exPcPlus4);
		checkBit($sformatf("%s exFetchExc", name), (idx % 3) == 1, exFetchExc);
		checkBit($sformatf("%s exReservedExc", name), expOp == RESERVED, exReservedExc);
		@(negedge clk);
		creditReturn = 1'b0;
		#(Period / 4);
		checkBit($sformatf("%s exValid one cycle", name), 1'b0, exValid);
	endtask

	// one cycle of a jump instruction against the credit model
	task automatic runCreditCycle(input logic valid, input logic ret, input logic stl,
		input string name);
		logic expAccept;
		@(negedge clk);
		instrValid   = valid;
		creditReturn = ret;
		stall        = stl;
		#(Period / 4);
		expAccept = valid && (modelCredits != 0) && !stl;
		checkBit($sformatf("%s instrReady", name), (modelCredits != 0) && !stl, instrReady);
		checkBit($sformatf("%s redirect", name), expAccept, redirect);
		checkBit($sformatf("%s exValid", name), prevAccept, exValid);
		prevAccept   = expAccept;
		acceptCount  = acceptCount + int'(valid && instrReady);
		modelCredits = modelCredits - int'(expAccept) + int'(ret);
	endtask

	initial begin
		seed         = 32'hbf8f_80c9;
		checkCount   = 0;
		valueErrors  = 0;
		otherErrors  = 0;
		timedOut     = 1'b0;
		arstN        = 1'b0;
		instr        = '0;
		pcPlus4      = '0;
		fetchExc     = 1'b0;
		instrValid   = 1'b0;
		forwardA     = FWD_REG;
		forwardB     = FWD_REG;
		aluOutM      = '0;
		resultW      = '0;
		stall        = 1'b0;
		hi           = '0;
		lo           = '0;
		cp0Rd        = '0;
		wbEnable     = 1'b0;
		wbAddr       = '0;
		wbData       = '0;
		creditReturn = 1'b0;
		for (int r = 0; r < 32; r++) begin
			shadowRegs[r] = '0;
		end

		addStim(rType(5'd1, 5'd2, 5'd3, 5'd5, 6'h21), 32'h0040_0004, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(rType(5'd5, 5'd6, 5'd4, 5'd0, 6'h23), 32'h0040_0008, FWD_MEM, FWD_WB, '0, '0, '0);
		addStim(rType(5'd8, 5'd9, 5'd7, 5'd0, 6'h24), 32'h0040_000c, FWD_WB, FWD_MEM, '0, '0, '0);
		addStim(rType(5'd0, 5'd11, 5'd10, 5'd0, 6'h25), 32'h0040_0010, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(rType(5'd13, 5'd0, 5'd12, 5'd31, 6'h2a), 32'h0040_0014, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(iType(6'h09, 5'd16, 5'd15, 16'hfffc), 32'h0040_0018, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(iType(6'h0c, 5'd18, 5'd17, 16'h8f0f), 32'h0040_001c, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(iType(6'h0d, 5'd20, 5'd19, 16'hf00d), 32'h0040_0020, FWD_MEM, FWD_REG, '0, '0, '0);
		addStim(iType(6'h0f, 5'd0, 5'd21, 16'hbeef), 32'h0040_0024, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(iType(6'h23, 5'd23, 5'd22, 16'h8004), 32'h0040_0028, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(iType(6'h2b, 5'd25, 5'd24, 16'h0010), 32'h0040_002c, FWD_REG, FWD_WB, '0, '0, '0);
		addStim(iType(6'h04, 5'd1, 5'd1, 16'hfff8), 32'h0040_0030, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(iType(6'h04, 5'd1, 5'd2, 16'h0040), 32'h0040_0034, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(iType(6'h05, 5'd3, 5'd3, 16'h0008), 32'h0040_0038, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(iType(6'h05, 5'd3, 5'd4, 16'h0020), 32'h0040_003c, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(iType(6'h06, 5'd5, 5'd0, 16'h8000), 32'h0040_0040, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(iType(6'h06, 5'd6, 5'd0, 16'h0100), 32'h0040_0044, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(iType(6'h07, 5'd6, 5'd0, 16'h7ffc), 32'h0040_0048, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(iType(6'h07, 5'd0, 5'd0, 16'h0004), 32'h0040_004c, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(jType(6'h02, 26'h012_3456), 32'ha000_0104, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(jType(6'h03, 26'h3ff_ffff), 32'h5000_0200, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(rType(5'd26, 5'd0, 5'd0, 5'd0, 6'h08), 32'h0040_0050, FWD_MEM, FWD_REG, '0, '0, '0);
		addStim(rType(5'd0, 5'd0, 5'd27, 5'd0, 6'h10), 32'h0040_0054, FWD_REG, FWD_REG,
			32'h1111_2222, 32'h3333_4444, 32'h5555_6666);
		addStim(rType(5'd0, 5'd0, 5'd28, 5'd0, 6'h12), 32'h0040_0058, FWD_REG, FWD_REG,
			32'h1111_2222, 32'h3333_4444, 32'h5555_6666);
		addStim(iType(6'h10, 5'd0, 5'd29, 16'h6000), 32'h0040_005c, FWD_REG, FWD_REG,
			32'h1111_2222, 32'h3333_4444, 32'h5555_6666);
		addStim(iType(6'h10, 5'd4, 5'd29, 16'h6000), 32'h0040_0060, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(iType(6'h3f, 5'd1, 5'd2, 16'h1234), 32'h0040_0064, FWD_REG, FWD_REG, '0, '0, '0);
		addStim(rType(5'd1, 5'd2, 5'd3, 5'd0, 6'h3f), 32'h0040_0068, FWD_REG, FWD_REG, '0, '0, '0);

		// jump offered during reset must not leak out
		instr      = jType(6'h02, 26'h000_0100);
		instrValid = 1'b1;
		repeat (5) @(negedge clk);
		#(Period / 4);
		checkBit("reset instrReady", 1'b0, instrReady);
		checkBit("reset redirect", 1'b0, redirect);
		checkBit("reset exValid", 1'b0, exValid);
		repeat (5) @(negedge clk);
		instrValid = 1'b0;
		arstN      = 1'b1;
		@(negedge clk);
		#(Period / 4);
		checkBit("reset release instrReady", 1'b1, instrReady);

		// writes to r0 must be dropped
		writeReg(5'd0, 32'hdead_beef);
		for (int r = 1; r < 32; r++) begin
			writeReg(r[4:0], $random(seed));
		end
		writeReg(5'd5, 32'h8000_0010);
		writeReg(5'd6, 32'h0000_0123);
		@(negedge clk);
		wbEnable = 1'b0;

		for (int i = 0; i < stimTable.size(); i++) begin
			applyEntry(i, stimTable[i]);
			if (timedOut) begin
				break;
			end
		end

		// back-pressure and stall against the credit model
		if (!timedOut) begin
			@(negedge clk);
			instr        = jType(6'h02, 26'h000_0040);
			pcPlus4      = 32'h0040_1000;
			forwardA     = FWD_REG;
			forwardB     = FWD_REG;
			fetchExc     = 1'b0;
			modelCredits = NumCredits;
			prevAccept   = 1'b0;
			acceptCount  = 0;
			for (int k = 0; k < NumCredits + 2; k++) begin
				runCreditCycle(1'b1, 1'b0, 1'b0, $sformatf("backpressure %0d", k));
			end
			checkWord("accepts before credit return", NumCredits, acceptCount);
			runCreditCycle(1'b1, 1'b1, 1'b0, "credit pulse");
			runCreditCycle(1'b1, 1'b0, 1'b0, "after pulse");
			runCreditCycle(1'b1, 1'b0, 1'b0, "empty again");
			checkWord("accepts after credit return", NumCredits + 1, acceptCount);
			for (int k = 0; k < NumCredits; k++) begin
				runCreditCycle(1'b0, 1'b1, 1'b0, $sformatf("refill %0d", k));
			end
			runCreditCycle(1'b1, 1'b0, 1'b1, "stall first");
			runCreditCycle(1'b1, 1'b0, 1'b1, "stall second");
			runCreditCycle(1'b1, 1'b0, 1'b0, "stall released");
			runCreditCycle(1'b0, 1'b1, 1'b0, "final return");
			runCreditCycle(1'b0, 1'b0, 1'b0, "idle");
		end

		finishRun();
	end

endmodule

`default_nettype wire

/* hdl/decodeCore.sv */
`default_nettype none

module decodeCore import mipsPkg::*; #(
	parameter int NumCredits = 2
) (
	input  logic     clk,
	input  logic     arstN,
	input  word_t    instr,
	input  word_t    pcPlus4,
	input  logic     fetchExc,
	input  logic     instrValid,
	output logic     instrReady,
	input  forward_t forwardA,
	input  forward_t forwardB,
	input  word_t    aluOutM,
	input  word_t    resultW,
	input  logic     stall,
	input  word_t    hi,
	input  word_t    lo,
	input  word_t    cp0Rd,
	output regAddr_t cp0Ra,
	input  logic     wbEnable,
	input  regAddr_t wbAddr,
	input  word_t    wbData,
	output logic     redirect,
	output word_t    redirectTarget,
	output logic     isJr,
	input  logic     creditReturn,
	output logic     exValid,
	output decOp_t   exOp,
	output regAddr_t exRs,
	output regAddr_t exRt,
	output regAddr_t exRd,
	output regAddr_t exShamt,
	output word_t    exImm,
	output word_t    exSrcA,
	output word_t    exSrcB,
	output word_t    exPcPlus4,
	output logic     exFetchExc,
	output logic     exReservedExc
);

	regAddr_t ra1;
	regAddr_t ra2;
	word_t    rd1;
	word_t    rd2;
	logic     accept;
	decOp_t   op;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t rd;
	regAddr_t shamt;
	word_t    immExt;
	word_t    srcA;
	word_t    srcB;
	logic     reserved;

	regFile regs (
		.clk   (clk),
		.arstN (arstN),
		.ra1   (ra1),
		.ra2   (ra2),
		.rd1   (rd1),
		.rd2   (rd2),
		.we    (wbEnable),
		.wa    (wbAddr),
		.wd    (wbData)
	);

	decodeStage decode (
		.instr          (instr),
		.pcPlus4        (pcPlus4),
		.rd1            (rd1),
		.rd2            (rd2),
		.ra1            (ra1),
		.ra2            (ra2),
		.forwardA       (forwardA),
		.forwardB       (forwardB),
		.aluOutM        (aluOutM),
		.resultW        (resultW),
		.hi             (hi),
		.lo             (lo),
		.cp0Rd          (cp0Rd),
		.cp0Ra          (cp0Ra),
		.accept         (accept),
		.op             (op),
		.rs             (rs),
		.rt             (rt),
		.rd             (rd),
		.shamt          (shamt),
		.immExt         (immExt),
		.srcA           (srcA),
		.srcB           (srcB),
		.reserved       (reserved),
		.redirect       (redirect),
		.redirectTarget (redirectTarget),
		.isJr           (isJr)
	);

	decodeExecReg #(
		.NumCredits (NumCredits)
	) deReg (
		.clk           (clk),
		.arstN         (arstN),
		.accept        (accept),
		.instrValid    (instrValid),
		.stall         (stall),
		.instrReady    (instrReady),
		.creditReturn  (creditReturn),
		.op            (op),
		.rs            (rs),
		.rt            (rt),
		.rd            (rd),
		.shamt         (shamt),
		.immExt        (immExt),
		.srcA          (srcA),
		.srcB          (srcB),
		.pcPlus4       (pcPlus4),
		.fetchExc      (fetchExc),
		.reserved      (reserved),
		.exValid       (exValid),
		.exOp          (exOp),
		.exRs          (exRs),
		.exRt          (exRt),
		.exRd          (exRd),
		.exShamt       (exShamt),
		.exImm         (exImm),
		.exSrcA        (exSrcA),
		.exSrcB        (exSrcB),
		.exPcPlus4     (exPcPlus4),
		.exFetchExc    (exFetchExc),
		.exReservedExc (exReservedExc)
	);

endmodule

`default_nettype wire

/* hdl/decodeExecReg.sv */
`default_nettype none

module decodeExecReg import mipsPkg::*; #(
	parameter int NumCredits = 2
) (
	input  logic     clk,
	input  logic     arstN,
	output logic     accept,
	input  logic     instrValid,
	input  logic     stall,
	output logic     instrReady,
	input  logic     creditReturn,
	input  decOp_t   op,
	input  regAddr_t rs,
	input  regAddr_t rt,
	input  regAddr_t rd,
	input  regAddr_t shamt,
	input  word_t    immExt,
	input  word_t    srcA,
	input  word_t    srcB,
	input  word_t    pcPlus4,
	input  logic     fetchExc,
	input  logic     reserved,
	output logic     exValid,
	output decOp_t   exOp,
	output regAddr_t exRs,
	output regAddr_t exRt,
	output regAddr_t exRd,
	output regAddr_t exShamt,
	output word_t    exImm,
	output word_t    exSrcA,
	output word_t    exSrcB,
	output word_t    exPcPlus4,
	output logic     exFetchExc,
	output logic     exReservedExc
);

	localparam int CreditWidth = $clog2(NumCredits + 1);

	logic [CreditWidth-1:0] credits;
	logic                   running;

	// goes high on the first edge after reset release
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			running <= 1'b0;
		end else begin
			running <= 1'b1;
		end
	end

	assign instrReady = running && (credits != '0) && !stall;
	assign accept     = instrValid && instrReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			credits <= CreditWidth'(NumCredits);
		end else begin
			case ({accept, creditReturn})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exValid <= 1'b0;
		end else begin
			exValid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			exOp          <= op;
			exRs          <= rs;
			exRt          <= rt;
			exRd          <= rd;
			exShamt       <= shamt;
			exImm         <= immExt;
			exSrcA        <= srcA;
			exSrcB        <= srcB;
			exPcPlus4     <= pcPlus4;
			exFetchExc    <= fetchExc;
			exReservedExc <= reserved;
		end
	end

	creditInRange: assert property (@(posedge clk) disable iff (!arstN)
		credits <= CreditWidth'(NumCredits))
		else $error("decodeExecReg: credit count above %0d", NumCredits);

	// execute returning a slot it never received
	noExtraReturn: assert property (@(posedge clk) disable iff (!arstN)
		(creditReturn && !accept) |-> (credits < CreditWidth'(NumCredits)))
		else $error("decodeExecReg: credit returned with all slots free");

endmodule

`default_nettype wire

/* hdl/decodeStage.sv */
`default_nettype none

module decodeStage import mipsPkg::*; (
	input  word_t    instr,
	input  word_t    pcPlus4,
	input  word_t    rd1,
	input  word_t    rd2,
	output regAddr_t ra1,
	output regAddr_t ra2,
	input  forward_t forwardA,
	input  forward_t forwardB,
	input  word_t    aluOutM,
	input  word_t    resultW,
	input  word_t    hi,
	input  word_t    lo,
	input  word_t    cp0Rd,
	output regAddr_t cp0Ra,
	input  logic     accept,
	output decOp_t   op,
	output regAddr_t rs,
	output regAddr_t rt,
	output regAddr_t rd,
	output regAddr_t shamt,
	output word_t    immExt,
	output word_t    srcA,
	output word_t    srcB,
	output logic     reserved,
	output logic     redirect,
	output word_t    redirectTarget,
	output logic     isJr
);

	logic [ImmWidth-1:0] imm;
	word_t               signExtImm;
	word_t               fwdA;
	word_t               fwdB;
	word_t               branchTarget;
	word_t               jumpTarget;
	logic                zeroExt;
	logic                isBranch;
	logic                isJump;
	logic                jrCtl;
	logic                taken;
	branchType_t         branchType;

	assign rs    = instr[25:21];
	assign rt    = instr[20:16];
	assign rd    = instr[15:11];
	assign shamt = instr[10:6];
	assign imm   = instr[ImmWidth-1:0];

	assign ra1   = rs;
	assign ra2   = rt;
	assign cp0Ra = rd;

	mainDecoder mainDec (
		.instr      (instr),
		.op         (op),
		.zeroExt    (zeroExt),
		.regDst     (),
		.aluSrcImm  (),
		.isBranch   (isBranch),
		.isJump     (isJump),
		.isJr       (jrCtl),
		.writesReg  (),
		.branchType (branchType),
		.reserved   (reserved)
	);

	assign signExtImm = {{(WordWidth-ImmWidth){imm[ImmWidth-1]}}, imm};

	// lui places the immediate in the upper half
	always_comb begin
		if (op == LUI) begin
			immExt = {imm, {(WordWidth-ImmWidth){1'b0}}};
		end else if (zeroExt) begin
			immExt = {{(WordWidth-ImmWidth){1'b0}}, imm};
		end else begin
			immExt = signExtImm;
		end
	end

	operandForward fwdMuxA (
		.regValue (rd1),
		.aluOutM  (aluOutM),
		.resultW  (resultW),
		.sel      (forwardA),
		.value    (fwdA)
	);

	operandForward fwdMuxB (
		.regValue (rd2),
		.aluOutM  (aluOutM),
		.resultW  (resultW),
		.sel      (forwardB),
		.value    (fwdB)
	);

	// move-from ops take operand A from hi, lo or cp0
	always_comb begin
		case (op)
			MFHI:    srcA = hi;
			MFLO:    srcA = lo;
			MFC0:    srcA = cp0Rd;
			default: srcA = fwdA;
		endcase
	end

	assign srcB = fwdB;

	branchUnit brUnit (
		.srcA       (fwdA),
		.srcB       (fwdB),
		.branchType (branchType),
		.taken      (taken)
	);

	assign branchTarget = pcPlus4 + {signExtImm[WordWidth-3:0], 2'b00};
	assign jumpTarget   = {pcPlus4[31:28], instr[JumpIndexWidth-1:0], 2'b00};

	always_comb begin
		if (jrCtl) begin
			redirectTarget = srcA;
		end else if (isJump) begin
			redirectTarget = jumpTarget;
		end else begin
			redirectTarget = branchTarget;
		end
	end

	// pc select only acts on an accepted instruction
	assign redirect = accept && (isJump || jrCtl || (isBranch && taken));
	assign isJr     = accept && jrCtl;

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`default_nettype none

module regFile import mipsPkg::*; (
	input  logic     clk,
	input  logic     arstN,
	input  regAddr_t ra1,
	input  regAddr_t ra2,
	output word_t    rd1,
	output word_t    rd2,
	input  logic     we,
	input  regAddr_t wa,
	input  word_t    wd
);

	localparam int NumRegs = 2 ** RegAddrWidth;

	word_t regs [NumRegs];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regs <= '{default: '0};
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	// reads see the value before a same-cycle write
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

/* hdl/operandForward.sv */
`default_nettype none

module operandForward import mipsPkg::*; (
	input  word_t    regValue,
	input  word_t    aluOutM,
	input  word_t    resultW,
	input  forward_t sel,
	output word_t    value
);

	always_comb begin
		case (sel)
			FWD_MEM: value = aluOutM;
			FWD_WB:  value = resultW;
			default: value = regValue;
		endcase
	end

	// hazard unit must never send the spare code
	selDefined: assert final ($isunknown(sel) || (sel inside {FWD_REG, FWD_MEM, FWD_WB}))
		else $error("operandForward: undefined forward select %0d", sel);

endmodule

`default_nettype wire

/* hdl/branchUnit.sv */
`default_nettype none

module branchUnit import mipsPkg::*; (
	input  word_t       srcA,
	input  word_t       srcB,
	input  branchType_t branchType,
	output logic        taken
);

	// zero compares treat operand A as signed
	always_comb begin
		case (branchType)
			BR_EQ:   taken = (srcA == srcB);
			BR_NE:   taken = (srcA != srcB);
			BR_LEZ:  taken = ($signed(srcA) <= 0);
			BR_GTZ:  taken = ($signed(srcA) > 0);
			default: taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/mainDecoder.sv */
`default_nettype none

module mainDecoder import mipsPkg::*; (
	input  word_t       instr,
	output decOp_t      op,
	output logic        zeroExt,
	output logic        regDst,
	output logic        aluSrcImm,
	output logic        isBranch,
	output logic        isJump,
	output logic        isJr,
	output logic        writesReg,
	output branchType_t branchType,
	output logic        reserved
);

	logic [OpcodeWidth-1:0] opcode;
	logic [FunctWidth-1:0]  funct;
	regAddr_t               rsField;

	assign opcode  = instr[31:26];
	assign funct   = instr[5:0];
	assign rsField = instr[25:21];

	always_comb begin
		op         = RESERVED;
		zeroExt    = 1'b0;
		regDst     = 1'b0;
		aluSrcImm  = 1'b0;
		isBranch   = 1'b0;
		isJump     = 1'b0;
		isJr       = 1'b0;
		writesReg  = 1'b0;
		branchType = BR_EQ;
		case (opcode)
			// special group, destination is rd
			6'b000000: begin
				regDst    = 1'b1;
				writesReg = 1'b1;
				case (funct)
					6'b100001: op = ADDU;
					6'b100011: op = SUBU;
					6'b100100: op = AND;
					6'b100101: op = OR;
					6'b101010: op = SLT;
					6'b010000: op = MFHI;
					6'b010010: op = MFLO;
					6'b001000: begin
						op        = JR;
						isJr      = 1'b1;
						regDst    = 1'b0;
						writesReg = 1'b0;
					end
					default: begin
						regDst    = 1'b0;
						writesReg = 1'b0;
					end
				endcase
			end
			6'b000010: begin
				op     = J;
				isJump = 1'b1;
			end
			// link register write is handled downstream
			6'b000011: begin
				op        = JAL;
				isJump    = 1'b1;
				writesReg = 1'b1;
			end
			6'b000100: begin
				op       = BEQ;
				isBranch = 1'b1;
			end
			6'b000101: begin
				op         = BNE;
				isBranch   = 1'b1;
				branchType = BR_NE;
			end
			6'b000110: begin
				op         = BLEZ;
				isBranch   = 1'b1;
				branchType = BR_LEZ;
			end
			6'b000111: begin
				op         = BGTZ;
				isBranch   = 1'b1;
				branchType = BR_GTZ;
			end
			6'b001001: begin
				op        = ADDIU;
				aluSrcImm = 1'b1;
				writesReg = 1'b1;
			end
			6'b001100: begin
				op        = ANDI;
				zeroExt   = 1'b1;
				aluSrcImm = 1'b1;
				writesReg = 1'b1;
			end
			6'b001101: begin
				op        = ORI;
				zeroExt   = 1'b1;
				aluSrcImm = 1'b1;
				writesReg = 1'b1;
			end
			6'b001111: begin
				op        = LUI;
				aluSrcImm = 1'b1;
				writesReg = 1'b1;
			end
			6'b100011: begin
				op        = LW;
				aluSrcImm = 1'b1;
				writesReg = 1'b1;
			end
			6'b101011: begin
				op        = SW;
				aluSrcImm = 1'b1;
			end
			// cop0, only the move-from form is supported
			6'b010000: begin
				if (rsField == '0) begin
					op        = MFC0;
					writesReg = 1'b1;
				end
			end
			default: op = RESERVED;
		endcase
	end

	assign reserved = (op == RESERVED);

endmodule

`default_nettype wire

/* hdl/mipsPkg.sv */
`default_nettype none

package mipsPkg;

	localparam int WordWidth      = 32;
	localparam int RegAddrWidth   = 5;
	localparam int ImmWidth       = 16;
	localparam int OpcodeWidth    = 6;
	localparam int FunctWidth     = 6;
	localparam int JumpIndexWidth = 26;

	typedef logic [WordWidth-1:0]    word_t;
	typedef logic [RegAddrWidth-1:0] regAddr_t;

	// decoded operation handed to execute
	typedef enum logic [4:0] {
		ADDU,
		SUBU,
		AND,
		OR,
		SLT,
		ADDIU,
		ANDI,
		ORI,
		LUI,
		LW,
		SW,
		BEQ,
		BNE,
		BLEZ,
		BGTZ,
		J,
		JAL,
		JR,
		MFHI,
		MFLO,
		MFC0,
		RESERVED
	} decOp_t;

	typedef enum logic [1:0] {
		BR_EQ,
		BR_NE,
		BR_LEZ,
		BR_GTZ
	} branchType_t;

	// operand source chosen by the hazard unit
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} forward_t;

endpackage

`default_nettype wire
